/* project.f */
+incdir+.
gbc_pkg.sv
core_ctrl_if.sv
bridge_settings.sv
dataslot_loader.sv
fast_forward_ctrl.sv
video_conditioner.sv
gbc_core_top.sv
tb_gbc_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gbc_core \
    -f project.f > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/Vtb_gbc_core > sim.log 2>&1 || { cat sim.log; echo "simulator error"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "failure found in sim.log"; exit 1; }
grep -q "test passed" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation clean"

/* tb_gbc_core.sv */
`include "gbc_defines.svh"

module tb_gbc_core;

    import gbc_pkg::*;

    localparam int TIMEOUT = 500;

    logic         clk_sys;
    logic         rst_n;
    logic         bridge_wr;
    bridge_addr_t bridge_addr;
    bridge_data_t bridge_wr_data;
    logic         dataslot_requestwrite;
    slot_id_t     dataslot_requestwrite_id;
    logic         dataslot_allcomplete;
    logic         ioctl_wr;
    dl_word_t     ioctl_dout;
    logic         cont1_key_r1;
    audio_t       audio_l_in;
    audio_t       audio_r_in;
    rgb_t         rgb_in;
    logic         hblank;
    logic         vblank;
    logic         hs_in;
    logic         vs_in;
    logic         core_reset;
    rgb_t         pal_color0;
    rgb_t         pal_color1;
    rgb_t         pal_color2;
    rgb_t         pal_color3;
    logic         fast_forward;
    audio_t       audio_l;
    audio_t       audio_r;
    rgb_t         video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;

    logic [31:0]  lfsr_state = 32'h91be_3eef;
    int           value_errors = 0;
    int           timeout_errors = 0;
    logic [127:0] pal_model = `PALETTE_DEFAULT;

    // expected video for the compare process, one cycle behind the stimulus
    rgb_t         exp_rgb;
    logic         exp_de;
    logic         exp_gray;
    logic         exp_valid = 1'b0;

    gbc_core_top u_gbc_core_top (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    //////////////////////////////
    // stimulus and reference
    //////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [7:0] ref_lum(input rgb_t c);
        int r;
        int g;
        int b;
        int sum;
        r = c[23:16];
        g = c[15:8];
        b = c[7:0];
        sum = r / 4 + r / 32 + g / 2 + g / 16 + b / 16 + b / 32;
        return 8'(sum % 256);
    endfunction

    // each word moves the palette up by 16 bits, low byte first
    function automatic logic [127:0] ref_palette(input logic [127:0] start,
                                                 input dl_word_t words [8], input int n);
        logic [127:0] p;
        p = start;
        for (int i = 0; i < n; i++) begin
            p = (p << 16) | {112'd0, words[i][7:0], words[i][15:8]};
        end
        return p;
    endfunction

    // returns {latch, memory} after a release
    function automatic logic [1:0] ref_tap(input logic held_mem, input int press_len);
        if ((press_len < `FF_TAP_CYCLES) && !held_mem) begin
            return 2'b11;
        end
        return 2'b00;
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected %06h, actual %06h", name, exp, act);
        end
    endtask

    task automatic check_audio(input string name, input audio_t exp, input audio_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input hold_cnt_t exp, input hold_cnt_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_palette(input string name, input logic [127:0] p);
        check_rgb({name, " color0"}, p[127:104], pal_color0);
        check_rgb({name, " color1"}, p[103:80], pal_color1);
        check_rgb({name, " color2"}, p[79:56], pal_color2);
        check_rgb({name, " color3"}, p[55:32], pal_color3);
    endtask

    always @(negedge clk_sys) begin
        if (exp_valid) begin
            check_bit("video de", exp_de, video_de);
            if (exp_gray) begin
                check_rgb("video gray", {ref_lum(exp_rgb), ref_lum(exp_rgb), ref_lum(exp_rgb)},
                          video_rgb);
            end else begin
                check_rgb("video rgb", exp_rgb, video_rgb);
            end
        end
    end

    //////////////////////////////
    // bus helpers
    //////////////////////////////

    task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
        @(negedge clk_sys);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        @(negedge clk_sys);
        bridge_wr      = 1'b0;
    endtask

    task automatic start_download(input slot_id_t id);
        @(negedge clk_sys);
        dataslot_requestwrite    = 1'b1;
        dataslot_requestwrite_id = id;
        @(negedge clk_sys);
        dataslot_requestwrite    = 1'b0;
    endtask

    task automatic press_button(input int cycles);
        @(negedge clk_sys);
        cont1_key_r1 = 1'b1;
        repeat (cycles) @(negedge clk_sys);
        cont1_key_r1 = 1'b0;
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_reset_request();
        hold_cnt_t n;
        n = '0;
        bridge_write(`BRIDGE_ADDR_RESET, 32'd1);
        while (core_reset && (n < TIMEOUT)) begin
            n++;
            @(negedge clk_sys);
        end
        if (n == TIMEOUT) begin
            timeout_errors++;
            $display("** Timeout: core_reset stayed high for %0d cycles", TIMEOUT);
        end
        check_count("reset hold", hold_cnt_t'(`RESET_HOLD_CYCLES), n);
    endtask

    task automatic test_palette_download();
        logic [31:0] v;
        dl_word_t    words [8];
        logic [127:0] start;
        start = pal_model;
        start_download(`SLOT_PALETTE);
        for (int i = 0; i < 8; i++) begin
            take_bits(16, v);
            words[i]   = v[15:0];
            ioctl_wr   = 1'b1;
            ioctl_dout = words[i];
            @(negedge clk_sys);
            check_palette($sformatf("palette word %0d", i), ref_palette(start, words, i + 1));
            check_bit("core_reset palette dl", 1'b0, core_reset);
        end
        ioctl_wr = 1'b0;
        pal_model = ref_palette(start, words, 8);
        @(negedge clk_sys);
        dataslot_allcomplete = 1'b1;
        @(negedge clk_sys);
        dataslot_allcomplete = 1'b0;
    endtask

    task automatic test_cart_download();
        logic [31:0] v;
        start_download(`SLOT_CART);
        check_bit("core_reset cart start", 1'b1, core_reset);
        for (int i = 0; i < 6; i++) begin
            take_bits(16, v);
            ioctl_wr   = 1'b1;
            ioctl_dout = v[15:0];
            @(negedge clk_sys);
        end
        ioctl_wr = 1'b0;
        @(negedge clk_sys);
        check_palette("palette after cart", pal_model);
        check_bit("core_reset cart end", 1'b1, core_reset);
        dataslot_allcomplete = 1'b1;
        @(negedge clk_sys);
        dataslot_allcomplete = 1'b0;
        check_bit("core_reset after complete", 1'b0, core_reset);
    endtask

    task automatic hold_and_check_audio(input string name, input logic muted);
        logic [31:0] v;
        @(negedge clk_sys);
        cont1_key_r1 = 1'b1;
        @(negedge clk_sys);
        check_bit({name, " ff held"}, 1'b1, fast_forward);
        for (int i = 0; i < 8; i++) begin
            take_bits(16, v);
            audio_l_in = audio_t'(v[15:0]);
            take_bits(16, v);
            audio_r_in = audio_t'(v[15:0]);
            #5;
            check_audio({name, " left"}, muted ? audio_t'(0) : audio_l_in, audio_l);
            check_audio({name, " right"}, muted ? audio_t'(0) : audio_r_in, audio_r);
            @(negedge clk_sys);
        end
        repeat (240) @(negedge clk_sys);
        cont1_key_r1 = 1'b0;
        repeat (4) @(negedge clk_sys);
        check_bit({name, " ff released"}, 1'b0, fast_forward);
        // no speedup, so the audio passes
        audio_l_in = 16'sd1234;
        #5;
        check_audio({name, " idle left"}, 16'sd1234, audio_l);
    endtask

    task automatic test_fast_forward();
        logic       mem;
        logic [1:0] nxt;
        bridge_write(`BRIDGE_ADDR_FF_EN, 32'd1);
        bridge_write(`BRIDGE_ADDR_FF_SND, 32'd0);
        hold_and_check_audio("ff muted", 1'b1);
        mem = 1'b0;
        for (int t = 0; t < 4; t++) begin
            press_button(10);
            nxt = ref_tap(mem, 10);
            mem = nxt[0];
            repeat (4) @(negedge clk_sys);
            check_bit($sformatf("tap %0d latch", t), nxt[1], fast_forward);
        end
        bridge_write(`BRIDGE_ADDR_FF_SND, 32'd1);
        hold_and_check_audio("ff sound on", 1'b0);
    endtask

    task automatic run_video(input int n, input logic gray);
        logic [31:0] v;
        logic [31:0] hb;
        logic [31:0] vb;
        for (int i = 0; i < n; i++) begin
            @(negedge clk_sys);
            take_bits(24, v);
            take_bits(1, hb);
            take_bits(1, vb);
            rgb_in    = v[23:0];
            hblank    = hb[0];
            vblank    = vb[0];
            exp_rgb   <= (hb[0] | vb[0]) ? rgb_t'(0) : v[23:0];
            exp_de    <= ~(hb[0] | vb[0]);
            exp_gray  <= gray;
            exp_valid <= 1'b1;
        end
        @(negedge clk_sys);
        exp_valid <= 1'b0;
        hblank    = 1'b1;
        vblank    = 1'b1;
    endtask

    task automatic check_sync(input string name, input logic is_hs, input int delay);
        logic pulse;
        @(negedge clk_sys);
        if (is_hs) begin
            hs_in = 1'b1;
        end else begin
            vs_in = 1'b1;
        end
        for (int cyc = 1; cyc <= delay + 3; cyc++) begin
            @(negedge clk_sys);
            pulse = is_hs ? video_hs : video_vs;
            check_bit($sformatf("%s cycle %0d", name, cyc), (cyc == delay), pulse);
            if (cyc == 2) begin
                hs_in = 1'b0;
                vs_in = 1'b0;
            end
        end
    endtask

    initial begin
        rst_n                    = 1'b0;
        bridge_wr                = 1'b0;
        bridge_addr              = '0;
        bridge_wr_data           = '0;
        dataslot_requestwrite    = 1'b0;
        dataslot_requestwrite_id = '0;
        dataslot_allcomplete     = 1'b0;
        ioctl_wr                 = 1'b0;
        ioctl_dout               = '0;
        cont1_key_r1             = 1'b0;
        audio_l_in               = '0;
        audio_r_in               = '0;
        rgb_in                   = '0;
        hblank                   = 1'b1;
        vblank                   = 1'b1;
        hs_in                    = 1'b0;
        vs_in                    = 1'b0;
        repeat (4) @(negedge clk_sys);
        rst_n = 1'b1;
        @(negedge clk_sys);

        // state straight out of reset
        check_bit("reset core_reset", 1'b0, core_reset);
        check_bit("reset video_de", 1'b0, video_de);
        check_bit("reset video_hs", 1'b0, video_hs);
        check_bit("reset video_vs", 1'b0, video_vs);
        check_bit("reset fast_forward", 1'b0, fast_forward);
        check_palette("reset palette", `PALETTE_DEFAULT);

        test_reset_request();
        test_palette_download();
        test_cart_download();
        test_fast_forward();
        run_video(32, 1'b0);
        bridge_write(`BRIDGE_ADDR_GRAY, 32'd1);
        run_video(32, 1'b1);
        check_sync("hsync", 1'b1, `HS_DELAY);
        check_sync("vsync", 1'b0, 1);

        @(negedge clk_sys);
        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if ((value_errors == 0) && (timeout_errors == 0)) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* gbc_core_top.sv */
module gbc_core_top (
    input  logic                  clk_sys,
    input  logic                  rst_n,

    // bridge
    input  logic                  bridge_wr,
    input  gbc_pkg::bridge_addr_t bridge_addr,
    input  gbc_pkg::bridge_data_t bridge_wr_data,

    // data slots
    input  logic                  dataslot_requestwrite,
    input  gbc_pkg::slot_id_t     dataslot_requestwrite_id,
    input  logic                  dataslot_allcomplete,
    input  logic                  ioctl_wr,
    input  gbc_pkg::dl_word_t     ioctl_dout,

    // controller and audio
    input  logic                  cont1_key_r1,
    input  gbc_pkg::audio_t       audio_l_in,
    input  gbc_pkg::audio_t       audio_r_in,

    // video from the lcd
    input  gbc_pkg::rgb_t         rgb_in,
    input  logic                  hblank,
    input  logic                  vblank,
    input  logic                  hs_in,
    input  logic                  vs_in,

    output logic                  core_reset,
    output gbc_pkg::rgb_t         pal_color0,
    output gbc_pkg::rgb_t         pal_color1,
    output gbc_pkg::rgb_t         pal_color2,
    output gbc_pkg::rgb_t         pal_color3,
    output logic                  fast_forward,
    output gbc_pkg::audio_t       audio_l,
    output gbc_pkg::audio_t       audio_r,
    output gbc_pkg::rgb_t         video_rgb,
    output logic                  video_de,
    output logic                  video_hs,
    output logic                  video_vs
);

    logic reset_req;
    logic download_reset;

    core_ctrl_if u_ctrl ();

    //////////////////////////////
    // control
    //////////////////////////////

    bridge_settings u_bridge_settings (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .bridge_wr      (bridge_wr),
        .bridge_addr    (bridge_addr),
        .bridge_wr_data (bridge_wr_data),
        .ctrl           (u_ctrl.settings),
        .reset_req      (reset_req)
    );

    dataslot_loader u_dataslot_loader (
        .clk_sys                  (clk_sys),
        .rst_n                    (rst_n),
        .dataslot_requestwrite    (dataslot_requestwrite),
        .dataslot_requestwrite_id (dataslot_requestwrite_id),
        .dataslot_allcomplete     (dataslot_allcomplete),
        .ioctl_wr                 (ioctl_wr),
        .ioctl_dout               (ioctl_dout),
        .ctrl                     (u_ctrl.loader),
        .download_reset           (download_reset),
        .pal_color0               (pal_color0),
        .pal_color1               (pal_color1),
        .pal_color2               (pal_color2),
        .pal_color3               (pal_color3)
    );

    // core held in reset by the bridge request or a rom/boot load
    assign core_reset = reset_req | download_reset;

    //////////////////////////////
    // speed and output path
    //////////////////////////////

    fast_forward_ctrl u_fast_forward_ctrl (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .ff_button    (cont1_key_r1),
        .ctrl         (u_ctrl.speed),
        .audio_l_in   (audio_l_in),
        .audio_r_in   (audio_r_in),
        .fast_forward (fast_forward),
        .audio_l      (audio_l),
        .audio_r      (audio_r)
    );

    video_conditioner u_video_conditioner (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .rgb_in    (rgb_in),
        .hblank    (hblank),
        .vblank    (vblank),
        .hs_in     (hs_in),
        .vs_in     (vs_in),
        .ctrl      (u_ctrl.video),
        .video_rgb (video_rgb),
        .video_de  (video_de),
        .video_hs  (video_hs),
        .video_vs  (video_vs)
    );

endmodule

/* video_conditioner.sv */
`include "gbc_defines.svh"

module video_conditioner (
    input  logic          clk_sys,
    input  logic          rst_n,
    input  gbc_pkg::rgb_t rgb_in,
    input  logic          hblank,
    input  logic          vblank,
    input  logic          hs_in,
    input  logic          vs_in,
    core_ctrl_if.video    ctrl,
    output gbc_pkg::rgb_t video_rgb,
    output logic          video_de,
    output logic          video_hs,
    output logic          video_vs
);

    import gbc_pkg::*;

    logic       de;
    logic       de_q;
    logic       hs_prev;
    logic       vs_prev;
    logic       hs_q;
    logic       vs_q;
    logic [3:0] hs_cnt;
    rgb_t       rgb_q;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic [7:0] lum;

    assign de = ~(hblank | vblank);

    //////////////////////////////
    // sync shaping
    //////////////////////////////

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            de_q    <= 1'b0;
            hs_prev <= 1'b0;
            vs_prev <= 1'b0;
            hs_q    <= 1'b0;
            vs_q    <= 1'b0;
            hs_cnt  <= '0;
        end else begin
            de_q    <= de;
            hs_prev <= hs_in;
            vs_prev <= vs_in;

            // vsync out is a single cycle at the rising edge
            vs_q <= vs_in & ~vs_prev;

            // hsync pushed back so it clears vsync
            hs_q <= (hs_cnt == 4'd1);
            if (hs_in && !hs_prev) begin
                hs_cnt <= 4'(`HS_DELAY - 1);
            end else if (hs_cnt != '0) begin
                hs_cnt <= hs_cnt - 1'b1;
            end
        end
    end

    // pixel data, blanked outside active video
    always_ff @(posedge clk_sys) begin
        rgb_q <= de ? rgb_in : '0;
    end

    //////////////////////////////
    // grayscale
    //////////////////////////////

    assign r = rgb_q[23:16];
    assign g = rgb_q[15:8];
    assign b = rgb_q[7:0];

    // approx 0.28r + 0.56g + 0.09b, wraps at 8 bits
    assign lum = (r >> 2) + (r >> 5) + (g >> 1) + (g >> 4) + (b >> 4) + (b >> 5);

    assign video_rgb = ctrl.gray_en ? {lum, lum, lum} : rgb_q;
    assign video_de  = de_q;
    assign video_hs  = hs_q;
    assign video_vs  = vs_q;

    // the scaler must never see both syncs in one cycle
    sync_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !(video_hs && video_vs));

endmodule

/* fast_forward_ctrl.sv */
`include "gbc_defines.svh"

module fast_forward_ctrl (
    input  logic            clk_sys,
    input  logic            rst_n,
    input  logic            ff_button,
    core_ctrl_if.speed      ctrl,
    input  gbc_pkg::audio_t audio_l_in,
    input  gbc_pkg::audio_t audio_r_in,
    output logic            fast_forward,
    output gbc_pkg::audio_t audio_l,
    output gbc_pkg::audio_t audio_r
);

    import gbc_pkg::*;

    hold_cnt_t press_cnt;
    logic      ff_req;
    logic      ff_req_q;
    logic      ff_latch;
    logic      ff_was_held;
    logic      mute;

    // no speedup while a download is running
    assign ff_req = ctrl.ff_en & ff_button & ~ctrl.downloading;

    //////////////////////////////
    // tap latch
    //////////////////////////////

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            ff_req_q     <= 1'b0;
            press_cnt    <= '0;
            ff_latch     <= 1'b0;
            ff_was_held  <= 1'b0;
            fast_forward <= 1'b0;
        end else begin
            ff_req_q <= ff_req;

            // saturate, only below-threshold matters
            if (ff_req && (press_cnt < hold_cnt_t'(`FF_TAP_CYCLES))) begin
                press_cnt <= press_cnt + 1'b1;
            end

            if (ff_req && !ff_req_q) begin
                ff_latch  <= 1'b0;
                press_cnt <= '0;
            end

            // release: short taps toggle the latch on every other tap
            if (!ff_req && ff_req_q) begin
                ff_was_held <= 1'b0;
                if ((press_cnt < hold_cnt_t'(`FF_TAP_CYCLES)) && !ff_was_held) begin
                    ff_was_held <= 1'b1;
                    ff_latch    <= 1'b1;
                end
            end

            fast_forward <= ff_req | ff_latch;
        end
    end

    //////////////////////////////
    // audio gating
    //////////////////////////////

    assign mute    = fast_forward & ~ctrl.ff_snd_en;
    assign audio_l = mute ? '0 : audio_l_in;
    assign audio_r = mute ? '0 : audio_r_in;

endmodule

/* dataslot_loader.sv */
`include "gbc_defines.svh"

module dataslot_loader (
    input  logic              clk_sys,
    input  logic              rst_n,
    input  logic              dataslot_requestwrite,
    input  gbc_pkg::slot_id_t dataslot_requestwrite_id,
    input  logic              dataslot_allcomplete,
    input  logic              ioctl_wr,
    input  gbc_pkg::dl_word_t ioctl_dout,
    core_ctrl_if.loader       ctrl,
    output logic              download_reset,
    output gbc_pkg::rgb_t     pal_color0,
    output gbc_pkg::rgb_t     pal_color1,
    output gbc_pkg::rgb_t     pal_color2,
    output gbc_pkg::rgb_t     pal_color3
);

    import gbc_pkg::*;

    logic         downloading;
    slot_id_t     slot_id;
    logic         cart_dl;
    logic         palette_dl;
    logic         boot_dl;
    logic [127:0] palette;

    //////////////////////////////
    // download tracking
    //////////////////////////////

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            downloading <= 1'b0;
            slot_id     <= '0;
        end else if (dataslot_requestwrite) begin
            downloading <= 1'b1;
            slot_id     <= dataslot_requestwrite_id;
        end else if (dataslot_allcomplete) begin
            downloading <= 1'b0;
        end
    end

    assign ctrl.downloading = downloading;

    // slot decode uses the id captured at the request
    assign cart_dl    = downloading && (slot_id == `SLOT_CART);
    assign palette_dl = downloading && (slot_id == `SLOT_PALETTE);
    assign boot_dl    = downloading && ((slot_id == `SLOT_CGB_BOOT) ||
                                        (slot_id == `SLOT_DMG_BOOT) ||
                                        (slot_id == `SLOT_SGB_BOOT));

    // hold the core in reset while rom or boot code is loading
    assign download_reset = cart_dl | boot_dl;

    //////////////////////////////
    // palette shift register
    //////////////////////////////

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            palette <= `PALETTE_DEFAULT;
        end else if (palette_dl && ioctl_wr) begin
            // words arrive big endian
            palette <= {palette[111:0], ioctl_dout[7:0], ioctl_dout[15:8]};
        end
    end

    assign pal_color0 = palette[127:104];
    assign pal_color1 = palette[103:80];
    assign pal_color2 = palette[79:56];
    assign pal_color3 = palette[55:32];

    // cart and boot words must not disturb the palette
    palette_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
        (ioctl_wr && !palette_dl) |=> $stable(palette));

endmodule

/* bridge_settings.sv */
`include "gbc_defines.svh"

module bridge_settings (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  bridge_wr,
    input  gbc_pkg::bridge_addr_t bridge_addr,
    input  gbc_pkg::bridge_data_t bridge_wr_data,
    core_ctrl_if.settings         ctrl,
    output logic                  reset_req
);

    import gbc_pkg::*;

    hold_cnt_t reset_cnt;
    logic      ff_en_q;
    logic      ff_snd_en_q;
    logic      gray_en_q;

    //////////////////////////////
    // write decode
    //////////////////////////////

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            reset_cnt   <= '0;
            ff_en_q     <= 1'b0;
            ff_snd_en_q <= 1'b0;
            gray_en_q   <= 1'b0;
        end else begin
            // countdown runs on its own once loaded
            if (reset_cnt != '0) begin
                reset_cnt <= reset_cnt - 1'b1;
            end

            if (bridge_wr) begin
                case (bridge_addr)
                    `BRIDGE_ADDR_RESET: begin
                        reset_cnt <= hold_cnt_t'(`RESET_HOLD_CYCLES);
                    end
                    `BRIDGE_ADDR_FF_EN: begin
                        ff_en_q <= bridge_wr_data[0];
                    end
                    `BRIDGE_ADDR_FF_SND: begin
                        ff_snd_en_q <= bridge_wr_data[0];
                    end
                    `BRIDGE_ADDR_GRAY: begin
                        gray_en_q <= bridge_wr_data[0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign ctrl.ff_en     = ff_en_q;
    assign ctrl.ff_snd_en = ff_snd_en_q;
    assign ctrl.gray_en   = gray_en_q;

    // request stays up for the whole countdown
    assign reset_req = (reset_cnt != '0);

    // a reset write restarts the window, never extends past the hold length
    reset_cnt_bound: assert property (@(posedge clk_sys) disable iff (!rst_n)
        reset_cnt <= hold_cnt_t'(`RESET_HOLD_CYCLES));

endmodule

/* core_ctrl_if.sv */
interface core_ctrl_if;

    // settings from the bridge register file
    logic ff_en;
    logic ff_snd_en;
    logic gray_en;

    // high while a data slot download is in progress
    logic downloading;

    modport settings (
        output ff_en,
        output ff_snd_en,
        output gray_en
    );

    modport loader (
        output downloading
    );

    modport speed (
        input ff_en,
        input ff_snd_en,
        input downloading
    );

    modport video (
        input gray_en
    );

endinterface

/* gbc_pkg.sv */
package gbc_pkg;

    //////////////////////////////
    // bridge bus
    //////////////////////////////

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    //////////////////////////////
    // data slot downloads
    //////////////////////////////

    typedef logic [15:0] slot_id_t;

    // one word from the data loader
    typedef logic [15:0] dl_word_t;

    //////////////////////////////
    // audio and video
    //////////////////////////////

    // r in [23:16], g in [15:8], b in [7:0]
    typedef logic [23:0] rgb_t;

    typedef logic signed [15:0] audio_t;

    // general purpose countdown / press counter
    typedef logic [31:0] hold_cnt_t;

endpackage

/* gbc_defines.svh */
`ifndef GBC_DEFINES_SVH
`define GBC_DEFINES_SVH

//////////////////////////////
// bridge register map
//////////////////////////////

// write here to request a timed core reset
`define BRIDGE_ADDR_RESET   32'h0000_0050
`define BRIDGE_ADDR_FF_EN   32'h0000_020C
`define BRIDGE_ADDR_FF_SND  32'h0000_0210
`define BRIDGE_ADDR_GRAY    32'h0000_0218

// length of the core reset request in clk_sys cycles
`define RESET_HOLD_CYCLES   64

//////////////////////////////
// data slot ids
//////////////////////////////

`define SLOT_CART           16'd1
`define SLOT_PALETTE        16'd3
`define SLOT_CGB_BOOT       16'd4
`define SLOT_DMG_BOOT       16'd5
`define SLOT_SGB_BOOT       16'd6

// press shorter than this counts as a tap
`define FF_TAP_CYCLES       200
`define HS_DELAY            7

// four 24-bit colours on top, low word unused
`define PALETTE_DEFAULT     128'h8282_1451_7356_305A_5F1A_3B49_0000_0000

`endif
